//--- verilog/imul_consts.svh
/*
 * sizing constants for the multi-lane iterative multiply unit
 */
`ifndef IMUL_CONSTS_SVH
`define IMUL_CONSTS_SVH

// number of iterative lanes, 2, 4 or 8
`define IMUL_LANES 4

// operand width, product is twice as wide
`define IMUL_WIDTH 32

// step counter width, counts IMUL_WIDTH-1 down to zero
`define IMUL_CNT_W 5

`endif

//--- verilog/imul_pkg.sv
/*
 * request and response payload types for the multiply unit
 */
`include "imul_consts.svh"

package imul_pkg;

  // ----------------------------------------
  // request payload
  // ----------------------------------------

  // both operands signed two's complement
  typedef struct packed {
    logic [`IMUL_WIDTH-1:0] a;
    logic [`IMUL_WIDTH-1:0] b;
  } mul_req_t;

  // ----------------------------------------
  // response payload
  // ----------------------------------------

  // full-width signed product
  typedef struct packed {
    logic [2*`IMUL_WIDTH-1:0] prod;
  } mul_resp_t;

endpackage

//--- verilog/imul_lane_dpath.sv
/*
 * shift-and-add datapath of one multiplier lane
 * magnitude, shift registers, step counter, accumulator, sign fix
 */
`timescale 1ns/1ps
`include "imul_consts.svh"

module imul_lane_dpath import imul_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      load,
  input  logic      step,
  input  mul_req_t  req,
  output logic      last,
  output mul_resp_t product
);

  localparam int W     = `IMUL_WIDTH;
  localparam int CNT_W = `IMUL_CNT_W;

  logic [W-1:0]     mag_a;
  logic [W-1:0]     mag_b;
  logic [2*W-1:0]   mcand_q;
  logic [W-1:0]     mplier_q;
  logic [2*W-1:0]   acc_q;
  logic             sign_q;
  logic [CNT_W-1:0] cnt_q;

  // ----------------------------------------
  // operand magnitudes
  // ----------------------------------------

  // most negative value maps to 2^(W-1), still fits unsigned
  assign mag_a = req.a[W-1] ? (~req.a + 1'b1) : req.a;
  assign mag_b = req.b[W-1] ? (~req.b + 1'b1) : req.b;

  // ----------------------------------------
  // step counter
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_q <= '0;
    end else if (load) begin
      cnt_q <= CNT_W'(W - 1);
    end else if (step) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // final step happens in the cycle the counter reads zero
  assign last = (cnt_q == '0);

  // ----------------------------------------
  // shift registers and accumulator
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (load) begin
      mcand_q  <= {{W{1'b0}}, mag_a};
      mplier_q <= mag_b;
      acc_q    <= '0;
      // product is negative when exactly one operand is
      sign_q   <= req.a[W-1] ^ req.b[W-1];
    end else if (step) begin
      // add or skip on the current multiplier bit
      if (mplier_q[0]) begin
        acc_q <= acc_q + mcand_q;
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // sign correction on the way out
  always_comb begin
    product.prod = sign_q ? (~acc_q + 1'b1) : acc_q;
  end

endmodule

//--- verilog/imul_lane.sv
/*
 * one iterative multiplier lane
 * IDLE/CALC/DONE control around the shift-and-add datapath
 */
`timescale 1ns/1ps
`include "imul_consts.svh"

module imul_lane import imul_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  mul_req_t  req,
  input  logic      req_val,
  output logic      req_rdy,
  output mul_resp_t resp,
  output logic      resp_val,
  input  logic      resp_rdy
);

  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } lane_state_t;

  lane_state_t state_q;
  lane_state_t state_next;
  logic        load;
  logic        step;
  logic        last;

  // ----------------------------------------
  // handshake and datapath controls
  // ----------------------------------------

  assign req_rdy  = (state_q == IDLE);
  assign resp_val = (state_q == DONE);

  // load on the accept edge, one step per CALC cycle
  assign load = req_val && req_rdy;
  assign step = (state_q == CALC);

  // ----------------------------------------
  // state register
  // ----------------------------------------

  always_comb begin
    state_next = state_q;
    case (state_q)
      IDLE: begin
        if (load) begin
          state_next = CALC;
        end
      end
      CALC: begin
        // counter at zero means this is the last step
        if (last) begin
          state_next = DONE;
        end
      end
      DONE: begin
        if (resp_val && resp_rdy) begin
          state_next = IDLE;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_next;
    end
  end

  imul_lane_dpath u_dpath (
    .clk     (clk),
    .reset   (reset),
    .load    (load),
    .step    (step),
    .req     (req),
    .last    (last),
    .product (resp)
  );

  // one accepted request gives exactly WIDTH steps, then a held result
  a_step_window: assert property (@(posedge clk) disable iff (reset)
    load |=> step [*`IMUL_WIDTH] ##1 (!step && resp_val));

endmodule

//--- verilog/imul_dispatch.sv
/*
 * round-robin steering of incoming requests to the lanes
 */
`timescale 1ns/1ps
`include "imul_consts.svh"

module imul_dispatch import imul_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  mul_req_t               req,
  input  logic                   req_val,
  output logic                   req_rdy,
  output mul_req_t               lane_req [`IMUL_LANES],
  output logic [`IMUL_LANES-1:0] lane_req_val,
  input  logic [`IMUL_LANES-1:0] lane_req_rdy
);

  localparam int LANES = `IMUL_LANES;
  localparam int PTR_W = $clog2(LANES);

  logic [PTR_W-1:0] ptr_q;

  // data goes to every lane, only the pointed lane sees val
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      lane_req[i]     = req;
      lane_req_val[i] = req_val && (ptr_q == PTR_W'(i));
    end
  end

  // busy pointed lane stalls the whole input
  assign req_rdy = lane_req_rdy[ptr_q];

  // advance on every request transfer, wrap at the last lane
  always_ff @(posedge clk) begin
    if (reset) begin
      ptr_q <= '0;
    end else if (req_val && req_rdy) begin
      ptr_q <= (ptr_q == PTR_W'(LANES - 1)) ? '0 : ptr_q + 1'b1;
    end
  end

  // stalled sender keeps val and payload until the transfer
  a_req_hold: assert property (@(posedge clk) disable iff (reset)
    (req_val && !req_rdy) |=> (req_val && $stable(req)));

endmodule

//--- verilog/imul_collect.sv
/*
 * round-robin draining of lane results into a one-entry output register
 */
`timescale 1ns/1ps
`include "imul_consts.svh"

module imul_collect import imul_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  mul_resp_t              lane_resp [`IMUL_LANES],
  input  logic [`IMUL_LANES-1:0] lane_resp_val,
  output logic [`IMUL_LANES-1:0] lane_resp_rdy,
  output mul_resp_t              resp,
  output logic                   resp_val,
  input  logic                   resp_rdy
);

  localparam int LANES = `IMUL_LANES;
  localparam int PTR_W = $clog2(LANES);

  logic [PTR_W-1:0] ptr_q;
  logic             val_q;
  mul_resp_t        resp_q;
  logic             free;
  logic             take;

  // ----------------------------------------
  // lane side
  // ----------------------------------------

  // register can take a new entry when empty or drained this cycle
  assign free = !val_q || resp_rdy;

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      lane_resp_rdy[i] = free && (ptr_q == PTR_W'(i));
    end
  end

  assign take = lane_resp_val[ptr_q] && free;

  // ----------------------------------------
  // output register
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr_q <= '0;
      val_q <= 1'b0;
    end else if (take) begin
      // same rotation as the dispatcher keeps request order
      ptr_q <= (ptr_q == PTR_W'(LANES - 1)) ? '0 : ptr_q + 1'b1;
      val_q <= 1'b1;
    end else if (resp_rdy) begin
      val_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      resp_q <= lane_resp[ptr_q];
    end
  end

  assign resp     = resp_q;
  assign resp_val = val_q;

  // stalled output keeps both val and data
  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp)));

endmodule

//--- verilog/imul_top.sv
/*
 * multi-lane signed multiply unit
 * dispatcher, lane array and in-order collector
 */
`timescale 1ns/1ps
`include "imul_consts.svh"

module imul_top import imul_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  mul_req_t  req,
  input  logic      req_val,
  output logic      req_rdy,
  output mul_resp_t resp,
  output logic      resp_val,
  input  logic      resp_rdy
);

  mul_req_t               lane_req [`IMUL_LANES];
  logic [`IMUL_LANES-1:0] lane_req_val;
  logic [`IMUL_LANES-1:0] lane_req_rdy;
  mul_resp_t              lane_resp [`IMUL_LANES];
  logic [`IMUL_LANES-1:0] lane_resp_val;
  logic [`IMUL_LANES-1:0] lane_resp_rdy;

  // ----------------------------------------
  // request rotation
  // ----------------------------------------

  imul_dispatch u_dispatch (
    .clk          (clk),
    .reset        (reset),
    .req          (req),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .lane_req     (lane_req),
    .lane_req_val (lane_req_val),
    .lane_req_rdy (lane_req_rdy)
  );

  // one iterative multiplier per lane
  for (genvar i = 0; i < `IMUL_LANES; i++) begin : g_lane
    imul_lane u_lane (
      .clk      (clk),
      .reset    (reset),
      .req      (lane_req[i]),
      .req_val  (lane_req_val[i]),
      .req_rdy  (lane_req_rdy[i]),
      .resp     (lane_resp[i]),
      .resp_val (lane_resp_val[i]),
      .resp_rdy (lane_resp_rdy[i])
    );
  end

  // ----------------------------------------
  // response rotation
  // ----------------------------------------

  imul_collect u_collect (
    .clk           (clk),
    .reset         (reset),
    .lane_resp     (lane_resp),
    .lane_resp_val (lane_resp_val),
    .lane_resp_rdy (lane_resp_rdy),
    .resp          (resp),
    .resp_val      (resp_val),
    .resp_rdy      (resp_rdy)
  );

endmodule

//--- tb/imul_tb.sv
/*
 * testbench for the multi-lane signed multiply unit
 * table and random stimulus, signed product model, in-order response checks
 */
`timescale 1ns/1ps
`include "imul_consts.svh"

module imul_tb import imul_pkg::*; ();

  localparam int TBL_N   = 11;
  localparam int RAND_N  = 200;
  localparam int TIMEOUT = 400;
  // rising edges from request transfer to the edge that samples resp_val high
  // counts the shift-and-add steps, the DONE hand-over and the output register
  localparam int LATENCY = `IMUL_WIDTH + 2;

  // one table row, operands and expected product
  typedef struct packed {
    logic [`IMUL_WIDTH-1:0]   a;
    logic [`IMUL_WIDTH-1:0]   b;
    logic [2*`IMUL_WIDTH-1:0] prod;
  } mul_case_t;

  logic      clk;
  logic      reset;
  mul_req_t  req;
  logic      req_val;
  logic      req_rdy;
  mul_resp_t resp;
  logic      resp_val;
  logic      resp_rdy;
  logic      rdy_random;
  int        stall_cycles;
  mul_case_t cases [TBL_N];

  // expected products and test names, in request order
  logic [2*`IMUL_WIDTH-1:0] exp_q [$];
  string                    name_q [$];

  imul_top u_imul_top (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("mismatch %s expected %h actual %h",
                              name, expected, actual));
    end
  endtask

  // full signed product of two sign-extended operands
  function automatic logic [63:0] signed_product(input logic [31:0] a,
                                                 input logic [31:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    sa = $signed(a);
    sb = $signed(b);
    return sa * sb;
  endfunction

  task automatic expect_result(input string name, input logic [63:0] prod);
    name_q.push_back(name);
    exp_q.push_back(prod);
  endtask

  // called on a falling edge, returns on the falling edge after the transfer
  task automatic send_req(input logic [31:0] a, input logic [31:0] b, output int waited);
    waited  = 0;
    req.a   = a;
    req.b   = b;
    req_val = 1'b1;
    // req_rdy follows the pointed lane state, settled since the rising edge
    while (!req_rdy) begin
      @(negedge clk);
      waited++;
      stall_cycles++;
      if (waited > TIMEOUT) begin
        stop_on_error("timeout, req_rdy stayed low too long");
      end
    end
    @(posedge clk);
    @(negedge clk);
    req_val = 1'b0;
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) begin
        stop_on_error("timeout, expected responses never arrived");
      end
    end
  endtask

  // ----------------------------------------
  // response side
  // ----------------------------------------

  initial begin : monitor
    string       exp_name;
    logic [63:0] exp_prod;
    forever begin
      @(negedge clk);
      if (rdy_random) begin
        resp_rdy = 1'($urandom_range(1, 0));
      end else begin
        resp_rdy = 1'b1;
      end
      // val and rdy high here means a transfer on the next rising edge
      if (!reset && resp_val && resp_rdy) begin
        if (exp_q.size() == 0) begin
          stop_on_error("response arrived with no request outstanding");
        end else begin
          exp_name = name_q.pop_front();
          exp_prod = exp_q.pop_front();
          check_value(exp_name, exp_prod, resp.prod);
        end
      end
    end
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------

  initial begin : stimulus
    int          seed_ret;
    int          waited;
    int          cycles;
    logic [31:0] ra;
    logic [31:0] rb;
    seed_ret     = $urandom(32'h1269_7b7a);
    reset        = 1'b1;
    req          = '0;
    req_val      = 1'b0;
    resp_rdy     = 1'b0;
    rdy_random   = 1'b0;
    stall_cycles = 0;
    cases = '{
      '{32'h0000_0000, 32'h0000_0000, 64'h0000_0000_0000_0000},
      '{32'h0000_0001, 32'h0000_0001, 64'h0000_0000_0000_0001},
      '{32'h0000_0000, 32'hFFFF_FFFB, 64'h0000_0000_0000_0000},
      '{32'hFFFF_FFFF, 32'h0000_0001, 64'hFFFF_FFFF_FFFF_FFFF},
      '{32'hFFFF_FFFF, 32'hFFFF_FFFF, 64'h0000_0000_0000_0001},
      '{32'h0000_0007, 32'hFFFF_FFFD, 64'hFFFF_FFFF_FFFF_FFEB},
      '{32'h0000_03E8, 32'h0000_07D0, 64'h0000_0000_001E_8480},
      '{32'h7FFF_FFFF, 32'h7FFF_FFFF, 64'h3FFF_FFFF_0000_0001},
      '{32'h8000_0000, 32'h8000_0000, 64'h4000_0000_0000_0000},
      '{32'h8000_0000, 32'hFFFF_FFFF, 64'h0000_0000_8000_0000},
      '{32'h8000_0000, 32'h7FFF_FFFF, 64'hC000_0000_8000_0000}
    };
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    // idle unit after reset
    check_value("reset_resp_val", 64'd0, resp_val);
    check_value("reset_req_rdy", 64'd1, req_rdy);

    // single request into an idle unit, 6 times -7
    expect_result("latency_product", 64'hFFFF_FFFF_FFFF_FFD6);
    send_req(32'd6, 32'hFFFF_FFF9, waited);
    cycles = 0;
    while (!resp_val) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        stop_on_error("timeout, resp_val never rose after a single request");
      end
    end
    // resp_val seen at this falling edge is sampled on the next rising one
    check_value("latency_cycles", LATENCY, cycles + 1);
    wait_drained();

    // back to back, first lanes fill at once, the next one stalls
    for (int i = 0; i < TBL_N; i++) begin
      expect_result($sformatf("table_%0d", i), cases[i].prod);
      send_req(cases[i].a, cases[i].b, waited);
      if (i < `IMUL_LANES) begin
        check_value("table_no_stall", 64'd0, waited);
      end else if (i == `IMUL_LANES) begin
        check_value("table_busy_stall", 64'd1, waited > 0);
      end
    end
    wait_drained();

    // random operands under random back-pressure
    rdy_random   = 1'b1;
    stall_cycles = 0;
    for (int i = 0; i < RAND_N; i++) begin
      ra = $urandom();
      rb = $urandom();
      expect_result($sformatf("random_%0d", i), signed_product(ra, rb));
      send_req(ra, rb, waited);
    end
    wait_drained();
    // a repeated response would hit the empty queue in the monitor
    repeat (2 * LATENCY) @(negedge clk);
    check_value("random_stall_seen", 64'd1, stall_cycles > 0);
    rdy_random = 1'b0;

    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- src.f
+incdir+verilog
verilog/imul_pkg.sv
verilog/imul_lane_dpath.sv
verilog/imul_lane.sv
verilog/imul_dispatch.sv
verilog/imul_collect.sv
verilog/imul_top.sv
tb/imul_tb.sv

//--- Makefile
TOP = imul_tb

all: run

compile:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
